// File: logic/benes_pkg.sv
`default_nettype none

package benes_pkg;

	// network geometry, one size for both directions
	localparam int LOG_SIZE   = 3;                 // lane address bits
	localparam int SIZE       = 1 << LOG_SIZE;     // lanes incl. dummies
	localparam int STAGE_NUM  = 2 * LOG_SIZE - 1;  // switch columns
	localparam int SWITCH_NUM = SIZE / 2;          // 2x2 switches per column

	// one column of switch settings
	// bit k set -> switch k crosses, clear -> straight
	typedef logic [SWITCH_NUM-1:0] col_sel_t;

	// whole network, entry s drives stage s
	typedef col_sel_t [STAGE_NUM-1:0] net_sel_t;

	// lane bit on which stage s pairs its lanes
	// butterfly half walks from msb down, inverse half walks back up
	// switch k joins the k-th lane with this bit clear to its partner with the bit set
	function automatic int pair_bit(input int stage);
		int bit_idx;
		if (stage < LOG_SIZE) begin
			bit_idx = LOG_SIZE - 1 - stage;  // butterfly
		end else begin
			bit_idx = stage - LOG_SIZE + 1;  // inverse butterfly
		end
		return bit_idx;
	endfunction

endpackage

`default_nettype wire

// File: logic/port_pad.sv
`timescale 1ns/100ps
`default_nettype none

// feeder for one network direction
// real ports go to the low lanes, the rest are zero dummies
module port_pad #(
	parameter int DATA_WIDTH = 32,
	parameter int SLOT_NUM   = 6
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [DATA_WIDTH-1:0]     i_ports [SLOT_NUM],
	input  benes_pkg::net_sel_t       i_select,
	output logic [DATA_WIDTH-1:0]     o_lanes [benes_pkg::SIZE],
	output benes_pkg::net_sel_t       o_select
);

	import benes_pkg::*;

	logic [DATA_WIDTH-1:0] padded [SIZE];  // ports widened to full lane count

	// port count has to fit the network
	if (SLOT_NUM < 1 || SLOT_NUM > SIZE) begin : g_bad_slot_num
		$error("port_pad: SLOT_NUM %0d outside 1..%0d", SLOT_NUM, SIZE);
	end

	always_comb begin
		for (int i = 0; i < SIZE; i++) begin
			padded[i] = '0;  // dummy lane
		end
		for (int i = 0; i < SLOT_NUM; i++) begin
			padded[i] = i_ports[i];  // real lane
		end
	end

	// settings are captured on the same edge as their data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < SIZE; i++) begin
				o_lanes[i] <= '0;
			end
			o_select <= '0;  // zero settings = straight paths while flushing
		end else begin
			o_lanes  <= padded;
			o_select <= i_select;
		end
	end

endmodule

`default_nettype wire

// File: logic/benes_stage.sv
`timescale 1ns/100ps
`default_nettype none

// one registered column of 2x2 switches
// uses entry STAGE of the settings, passes all settings on unchanged
module benes_stage #(
	parameter int DATA_WIDTH = 32,
	parameter int STAGE      = 0
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [DATA_WIDTH-1:0]     i_lanes [benes_pkg::SIZE],
	input  benes_pkg::net_sel_t       i_select,
	output logic [DATA_WIDTH-1:0]     o_lanes [benes_pkg::SIZE],
	output benes_pkg::net_sel_t       o_select
);

	import benes_pkg::*;

	localparam int PB = pair_bit(STAGE);  // lane bit this column pairs on

	logic [DATA_WIDTH-1:0] sw_lanes [SIZE];  // switched, not yet registered
	col_sel_t              col_sel;          // this column's settings

	if (STAGE < 0 || STAGE >= STAGE_NUM) begin : g_bad_stage
		$error("benes_stage: STAGE %0d outside 0..%0d", STAGE, STAGE_NUM - 1);
	end

	assign col_sel = i_select[STAGE];

	for (genvar k = 0; k < SWITCH_NUM; k++) begin : g_switch
		// k-th lane with bit PB clear, i.e. k with a zero inserted at PB
		localparam int LO = ((k >> PB) << (PB + 1)) | (k & ((1 << PB) - 1));
		localparam int HI = LO | (1 << PB);  // partner lane

		assign sw_lanes[LO] = col_sel[k] ? i_lanes[HI] : i_lanes[LO];  // cross or keep
		assign sw_lanes[HI] = col_sel[k] ? i_lanes[LO] : i_lanes[HI];
	end

	// data and settings advance together
	// so later columns see the settings of their own item
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < SIZE; i++) begin
				o_lanes[i] <= '0;
			end
			o_select <= '0;
		end else begin
			o_lanes  <= sw_lanes;
			o_select <= i_select;  // whole vector, spent entries too
		end
	end

endmodule

`default_nettype wire

// File: logic/port_trim.sv
`timescale 1ns/100ps
`default_nettype none

// drain for one network direction
// keeps the real lanes, dummy lanes end here
module port_trim #(
	parameter int DATA_WIDTH = 32,
	parameter int SLOT_NUM   = 6
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [DATA_WIDTH-1:0]     i_lanes [benes_pkg::SIZE],
	output logic [DATA_WIDTH-1:0]     o_ports [SLOT_NUM]
);

	import benes_pkg::*;

	if (SLOT_NUM < 1 || SLOT_NUM > SIZE) begin : g_bad_slot_num
		$error("port_trim: SLOT_NUM %0d outside 1..%0d", SLOT_NUM, SIZE);
	end

	// output register, last pipeline step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < SLOT_NUM; i++) begin
				o_ports[i] <= '0;
			end
		end else begin
			for (int i = 0; i < SLOT_NUM; i++) begin
				o_ports[i] <= i_lanes[i];  // lane i -> port i
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/benes_network.sv
`timescale 1ns/100ps
`default_nettype none

// one direction of the crossbar
// pad (1) + STAGE_NUM switch columns (1 each) + trim (1) cycles
module benes_network #(
	parameter int DATA_WIDTH = 32,
	parameter int SLOT_NUM   = 6
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [DATA_WIDTH-1:0]     i_ports [SLOT_NUM],
	input  benes_pkg::net_sel_t       i_select,
	output logic [DATA_WIDTH-1:0]     o_ports [SLOT_NUM]
);

	import benes_pkg::*;

	// link s feeds stage s, link STAGE_NUM feeds the drain
	logic [DATA_WIDTH-1:0] lanes [STAGE_NUM+1][SIZE];
	net_sel_t              sel   [STAGE_NUM+1];  // settings riding beside each link

	port_pad #(
		.DATA_WIDTH (DATA_WIDTH),
		.SLOT_NUM   (SLOT_NUM)
	) pad_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_ports  (i_ports),
		.i_select (i_select),
		.o_lanes  (lanes[0]),
		.o_select (sel[0])
	);

	for (genvar s = 0; s < STAGE_NUM; s++) begin : g_stage
		benes_stage #(
			.DATA_WIDTH (DATA_WIDTH),
			.STAGE      (s)  // picks pairing and settings entry
		) stage_inst (
			.clk      (clk),
			.rst_n    (rst_n),
			.i_lanes  (lanes[s]),
			.i_select (sel[s]),
			.o_lanes  (lanes[s+1]),
			.o_select (sel[s+1])
		);
	end

	// settings stop at the last column, only lanes go on
	port_trim #(
		.DATA_WIDTH (DATA_WIDTH),
		.SLOT_NUM   (SLOT_NUM)
	) trim_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_lanes (lanes[STAGE_NUM]),
		.o_ports (o_ports)
	);

endmodule

`default_nettype wire

// File: logic/interconnect_benes.sv
`timescale 1ns/100ps
`default_nettype none

// buffer <-> compute module crossbar
// two independent benes networks, 7 cycles each, new routing every cycle
module interconnect_benes #(
	parameter int DATA_WIDTH = 32,  // word width
	parameter int SLOT_NUM   = 6    // real ports per direction
) (
	input  logic                      clk,
	input  logic                      rst_n,

	// buffer slots -> module inputs
	input  logic [DATA_WIDTH-1:0]     i_ram_outputs    [SLOT_NUM],
	input  benes_pkg::net_sel_t       i_module_select,
	output logic [DATA_WIDTH-1:0]     o_module_inputs  [SLOT_NUM],

	// module outputs -> buffer slots
	input  logic [DATA_WIDTH-1:0]     i_module_outputs [SLOT_NUM],
	input  benes_pkg::net_sel_t       i_slot_select,
	output logic [DATA_WIDTH-1:0]     o_ram_inputs     [SLOT_NUM]
);

	// ram to module, steered by i_module_select
	benes_network #(
		.DATA_WIDTH (DATA_WIDTH),
		.SLOT_NUM   (SLOT_NUM)
	) net_r2m (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_ports  (i_ram_outputs),
		.i_select (i_module_select),
		.o_ports  (o_module_inputs)
	);

	// module to ram, steered by i_slot_select
	// shares nothing with net_r2m
	benes_network #(
		.DATA_WIDTH (DATA_WIDTH),
		.SLOT_NUM   (SLOT_NUM)
	) net_m2r (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_ports  (i_module_outputs),
		.i_select (i_slot_select),
		.o_ports  (o_ram_inputs)
	);

endmodule

`default_nettype wire

// File: bench/interconnect_benes_chk.sv
`timescale 1ns/100ps
`default_nettype none

// column checks, bound into every benes_stage
module interconnect_benes_chk #(
	parameter int DATA_WIDTH = 32,
	parameter int STAGE      = 0
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [DATA_WIDTH-1:0]     i_lanes [benes_pkg::SIZE],
	input  benes_pkg::net_sel_t       i_select,
	input  logic [DATA_WIDTH-1:0]     o_lanes [benes_pkg::SIZE],
	input  benes_pkg::net_sel_t       o_select
);

	import benes_pkg::*;

	logic [SIZE-1:0][DATA_WIDTH-1:0] in_flat;   // packed copies for $past
	logic [SIZE-1:0][DATA_WIDTH-1:0] out_flat;
	logic [DATA_WIDTH-1:0]           in_xor;    // column signature
	logic [DATA_WIDTH-1:0]           out_xor;

	always_comb begin
		in_xor  = '0;
		out_xor = '0;
		for (int i = 0; i < SIZE; i++) begin
			in_flat[i]  = i_lanes[i];
			out_flat[i] = o_lanes[i];
			in_xor      = in_xor ^ i_lanes[i];
			out_xor     = out_xor ^ o_lanes[i];
		end
	end

	// switches only move words, so the xor of a column survives one cycle
	xor_kept: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> out_xor == $past(in_xor))
		else $error("stage %0d lost or duplicated a word", STAGE);

	// settings ride one column further, untouched
	sel_forwarded: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> o_select == $past(i_select))
		else $error("stage %0d changed the carried settings", STAGE);

	// all switches straight -> lanes pass in place
	straight_kept: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) && $past(i_select[STAGE]) == '0 |-> out_flat == $past(in_flat))
		else $error("stage %0d moved a lane with clear settings", STAGE);

endmodule

bind benes_stage interconnect_benes_chk #(
	.DATA_WIDTH (DATA_WIDTH),
	.STAGE      (STAGE)
) chk_inst (
	.clk      (clk),
	.rst_n    (rst_n),
	.i_lanes  (i_lanes),
	.i_select (i_select),
	.o_lanes  (o_lanes),
	.o_select (o_select)
);

`default_nettype wire

// File: bench/interconnect_benes_tb.sv
`timescale 1ns/100ps
`default_nettype none

module interconnect_benes_tb;

	import benes_pkg::*;

	localparam int DATA_WIDTH = 32;
	localparam int SLOT_NUM   = 6;
	localparam int LATENCY    = 7;   // pad + 5 columns + trim
	localparam int CLK_HALF   = 20;  // 40 ns period

	typedef logic [SLOT_NUM-1:0][DATA_WIDTH-1:0] ports_t;  // one item, packed for queues
	typedef logic [SIZE-1:0][DATA_WIDTH-1:0]     lanes_t;

	logic                  clk;
	logic                  rst_n;
	logic [DATA_WIDTH-1:0] ram_outputs    [SLOT_NUM];
	logic [DATA_WIDTH-1:0] module_outputs [SLOT_NUM];
	logic [DATA_WIDTH-1:0] module_inputs  [SLOT_NUM];
	logic [DATA_WIDTH-1:0] ram_inputs     [SLOT_NUM];
	net_sel_t              module_select;
	net_sel_t              slot_select;

	integer seed      = 95;
	int     cycle     = 0;       // negedge count
	bit     feeding   = 1'b0;    // inputs carry real items
	string  item_name = "idle";

	// expected items, oldest first
	ports_t exp_r2m_q [$];
	ports_t exp_m2r_q [$];
	string  name_q    [$];
	int     due_q     [$];  // negedge on which the item shows up

	interconnect_benes #(
		.DATA_WIDTH (DATA_WIDTH),
		.SLOT_NUM   (SLOT_NUM)
	) interconnect_benes_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.i_ram_outputs    (ram_outputs),
		.i_module_select  (module_select),
		.o_module_inputs  (module_inputs),
		.i_module_outputs (module_outputs),
		.i_slot_select    (slot_select),
		.o_ram_inputs     (ram_inputs)
	);

	always #CLK_HALF clk = ~clk;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string test, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("CHECK FAILED %s expected %h actual %h", test, expected, actual));
		end
	endtask

	// pad with zero lanes, run five switch columns, keep the real ports
	function automatic ports_t route_model(input ports_t ports, input net_sel_t sel);
		lanes_t lanes;
		lanes_t nxt;
		ports_t res;
		int     b;
		int     k;
		int     hi;
		lanes = '0;  // dummy lanes
		for (int i = 0; i < SLOT_NUM; i++) begin
			lanes[i] = ports[i];
		end
		for (int s = 0; s < STAGE_NUM; s++) begin
			if (s < LOG_SIZE) begin
				b = LOG_SIZE - 1 - s;  // butterfly, msb first
			end else begin
				b = s - LOG_SIZE + 1;  // inverse, back up
			end
			nxt = lanes;
			k   = 0;
			for (int lo = 0; lo < SIZE; lo++) begin
				if (((lo >> b) & 1) == 0) begin  // k-th lane with bit b clear
					hi = lo | (1 << b);
					if (sel[s][k]) begin
						nxt[lo] = lanes[hi];
						nxt[hi] = lanes[lo];
					end
					k++;
				end
			end
			lanes = nxt;
		end
		for (int i = 0; i < SLOT_NUM; i++) begin
			res[i] = lanes[i];
		end
		return res;
	endfunction

	function automatic ports_t random_ports();
		ports_t res;
		for (int i = 0; i < SLOT_NUM; i++) begin
			res[i] = DATA_WIDTH'($random(seed));
		end
		return res;
	endfunction

	// one item per rising edge, both directions at once
	task automatic drive_item(input string name, input ports_t r2m, input net_sel_t r2m_sel,
		input ports_t m2r, input net_sel_t m2r_sel);
		@(posedge clk);
		item_name = name;
		for (int i = 0; i < SLOT_NUM; i++) begin
			ram_outputs[i]    <= r2m[i];
			module_outputs[i] <= m2r[i];
		end
		module_select <= r2m_sel;
		slot_select   <= m2r_sel;
	endtask

	// outputs and inputs both settled at the falling edge
	always @(negedge clk) begin
		ports_t exp_r2m;
		ports_t exp_m2r;
		ports_t act_r2m;
		ports_t act_m2r;
		ports_t in_r2m;
		ports_t in_m2r;
		string  name;
		cycle = cycle + 1;
		for (int i = 0; i < SLOT_NUM; i++) begin
			act_r2m[i] = module_inputs[i];
			act_m2r[i] = ram_inputs[i];
			in_r2m[i]  = ram_outputs[i];
			in_m2r[i]  = module_outputs[i];
		end
		if (due_q.size() > 0 && due_q[0] == cycle) begin
			void'(due_q.pop_front());
			exp_r2m = exp_r2m_q.pop_front();
			exp_m2r = exp_m2r_q.pop_front();
			name    = name_q.pop_front();
		end else begin
			exp_r2m = '0;  // reset or flushing pipe
			exp_m2r = '0;
			name    = rst_n ? "idle" : "reset";
		end
		for (int i = 0; i < SLOT_NUM; i++) begin
			check_value($sformatf("%s r2m port %0d", name, i), exp_r2m[i], act_r2m[i]);
			check_value($sformatf("%s m2r port %0d", name, i), exp_m2r[i], act_m2r[i]);
		end
		if (feeding) begin  // sampled on the next rising edge
			exp_r2m_q.push_back(route_model(in_r2m, module_select));
			exp_m2r_q.push_back(route_model(in_m2r, slot_select));
			name_q.push_back(item_name);
			due_q.push_back(cycle + LATENCY);
		end
	end

	initial begin
		int       wait_cnt;
		ports_t   fixed;
		net_sel_t sel_a;
		net_sel_t dummy_sel;
		clk   = 1'b0;
		rst_n = 1'b0;
		for (int i = 0; i < SLOT_NUM; i++) begin
			ram_outputs[i]    = '0;
			module_outputs[i] = '0;
		end
		module_select = '0;
		slot_select   = '0;

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		wait_cnt = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			wait_cnt++;
			if (wait_cnt > 8) begin
				fail_run("timeout waiting for reset release");
			end
		end
		feeding = 1'b1;

		// all switches straight
		for (int n = 0; n < 16; n++) begin
			drive_item("straight", random_ports(), '0, random_ports(), '0);
		end
		// new random routing every cycle
		for (int n = 0; n < 100; n++) begin
			drive_item("random", random_ports(), net_sel_t'($random(seed)),
				random_ports(), net_sel_t'($random(seed)));
		end
		// same words, back-to-back settings
		fixed = random_ports();
		for (int n = 0; n < 16; n++) begin
			sel_a = net_sel_t'($random(seed));
			drive_item("pipeline", fixed, sel_a, fixed, ~sel_a);
		end
		// r2m random, m2r all crossing
		for (int n = 0; n < 32; n++) begin
			drive_item("independent", random_ports(), net_sel_t'($random(seed)),
				random_ports(), '1);
		end
		// column 0 pulls dummy lanes k+4 onto real lanes
		dummy_sel = '0;
		for (int k = 0; k < SWITCH_NUM; k++) begin
			if (k + SWITCH_NUM >= SLOT_NUM) begin
				dummy_sel[0][k] = 1'b1;
			end
		end
		for (int n = 0; n < 8; n++) begin
			drive_item("dummy", random_ports(), dummy_sel, random_ports(), dummy_sel);
		end

		@(posedge clk);
		for (int i = 0; i < SLOT_NUM; i++) begin
			ram_outputs[i]    <= '0;
			module_outputs[i] <= '0;
		end
		module_select <= '0;
		slot_select   <= '0;
		feeding = 1'b0;

		wait_cnt = 0;
		while (due_q.size() != 0) begin  // last items still in flight
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > 4 * LATENCY) begin
				fail_run("timeout waiting for the pipeline to drain");
			end
		end
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
logic/benes_pkg.sv
logic/port_pad.sv
logic/benes_stage.sv
logic/port_trim.sv
logic/benes_network.sv
logic/interconnect_benes.sv
bench/interconnect_benes_chk.sv
bench/interconnect_benes_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module interconnect_benes_tb \
	-f compile.f \
	--Mdir obj_dir \
	-o interconnect_benes_sim

./obj_dir/interconnect_benes_sim
